// File: source/clint_pkg.sv
package clint_pkg;

    // bus state machine
    typedef enum logic [1:0] {
        IDLE,
        READ_RESP,
        WRITE_DATA,
        WRITE_RESP
    } fsm_state_e;

    // register selected by the decoded address
    typedef enum logic [2:0] {
        SEL_MSIP,
        SEL_CMP_LO,
        SEL_CMP_HI,
        SEL_TIME_LO,
        SEL_TIME_HI,
        SEL_NONE
    } reg_sel_e;

    // offsets within the CLINT window, address bits 15:0
    localparam logic [15:0] ADDR_MSIP    = 16'h0000;
    localparam logic [15:0] ADDR_CMP_LO  = 16'h4000;
    localparam logic [15:0] ADDR_CMP_HI  = 16'h4004;
    localparam logic [15:0] ADDR_TIME_LO = 16'hBFF8;
    localparam logic [15:0] ADDR_TIME_HI = 16'hBFFC;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    function automatic reg_sel_e decode_addr(input logic [15:0] offset);
        reg_sel_e sel;
        case (offset)
            ADDR_MSIP:    sel = SEL_MSIP;
            ADDR_CMP_LO:  sel = SEL_CMP_LO;
            ADDR_CMP_HI:  sel = SEL_CMP_HI;
            ADDR_TIME_LO: sel = SEL_TIME_LO;
            ADDR_TIME_HI: sel = SEL_TIME_HI;
            default:      sel = SEL_NONE;
        endcase
        return sel;
    endfunction

    // replace the strobed bytes of a word
    function automatic logic [31:0] strobe_merge(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] merged;
        int          i;
        merged = old_word;
        for (i = 0; i < 4; i++)
        begin
            if (strb[i])
            begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: source/clint_axi_fsm.sv
module clint_axi_fsm (
    input  logic                clock,
    input  logic                S_AXI_ARESETN,
    // read address
    input  logic [31:0]         s_axi_araddr,
    input  logic                s_axi_arvalid,
    input  logic [3:0]          s_axi_arid,
    output logic                s_axi_arready,
    // read data
    input  logic                s_axi_rready,
    output logic [31:0]         s_axi_rdata,
    output logic [1:0]          s_axi_rresp,
    output logic                s_axi_rvalid,
    output logic [3:0]          s_axi_rid,
    // write address
    input  logic [31:0]         s_axi_awaddr,
    input  logic                s_axi_awvalid,
    input  logic [3:0]          s_axi_awid,
    output logic                s_axi_awready,
    // write data
    input  logic [31:0]         s_axi_wdata,
    input  logic [3:0]          s_axi_wstrb,
    input  logic                s_axi_wvalid,
    output logic                s_axi_wready,
    // write response
    input  logic                s_axi_bready,
    output logic [1:0]          s_axi_bresp,
    output logic                s_axi_bvalid,
    output logic [3:0]          s_axi_bid,
    // register side
    input  logic [31:0]         reg_rdata,
    output logic                reg_wr,
    output clint_pkg::reg_sel_e reg_sel,
    output logic [31:0]         reg_wdata,
    output logic [3:0]          reg_wstrb
);

    clint_pkg::fsm_state_e state;
    logic                  active;
    logic                  ar_hs;
    logic                  aw_hs;
    logic                  w_hs;
    logic [1:0]            resp;
    logic [3:0]            id_q;
    logic [31:0]           rdata_q;

    // active stays low through reset so no ready is raised early
    assign s_axi_awready = active && (state == clint_pkg::IDLE);
    // writes win over a read offered in the same cycle
    assign s_axi_arready = s_axi_awready && !s_axi_awvalid;
    assign s_axi_wready  = (state == clint_pkg::WRITE_DATA);

    assign ar_hs = s_axi_arvalid && s_axi_arready;
    assign aw_hs = s_axi_awvalid && s_axi_awready;
    assign w_hs  = s_axi_wvalid && s_axi_wready;

    assign resp = (reg_sel == clint_pkg::SEL_NONE) ? clint_pkg::RESP_SLVERR
                                                   : clint_pkg::RESP_OKAY;

    assign s_axi_rresp = resp;
    assign s_axi_bresp = resp;
    assign s_axi_rid   = id_q;
    assign s_axi_bid   = id_q;
    assign s_axi_rdata = rdata_q;

    always_ff @(posedge clock or negedge S_AXI_ARESETN)
    begin
        if (!S_AXI_ARESETN)
        begin
            state        <= clint_pkg::IDLE;
            active       <= 1'b0;
            s_axi_rvalid <= 1'b0;
            s_axi_bvalid <= 1'b0;
            reg_wr       <= 1'b0;
            reg_sel      <= clint_pkg::SEL_NONE;
        end
        else
        begin
            active <= 1'b1;
            // unmapped writes never reach the registers
            reg_wr <= w_hs && (reg_sel != clint_pkg::SEL_NONE);
            case (state)
                clint_pkg::IDLE:
                begin
                    if (aw_hs)
                    begin
                        state   <= clint_pkg::WRITE_DATA;
                        reg_sel <= clint_pkg::decode_addr(s_axi_awaddr[15:0]);
                    end
                    else if (ar_hs)
                    begin
                        state   <= clint_pkg::READ_RESP;
                        reg_sel <= clint_pkg::decode_addr(s_axi_araddr[15:0]);
                    end
                end
                clint_pkg::READ_RESP:
                begin
                    // first cycle samples the register and raises rvalid
                    if (!s_axi_rvalid)
                    begin
                        s_axi_rvalid <= 1'b1;
                    end
                    else if (s_axi_rready)
                    begin
                        s_axi_rvalid <= 1'b0;
                        state        <= clint_pkg::IDLE;
                    end
                end
                clint_pkg::WRITE_DATA:
                begin
                    if (w_hs)
                    begin
                        state <= clint_pkg::WRITE_RESP;
                    end
                end
                clint_pkg::WRITE_RESP:
                begin
                    // bvalid lines up with the register update
                    if (!s_axi_bvalid)
                    begin
                        s_axi_bvalid <= 1'b1;
                    end
                    else if (s_axi_bready)
                    begin
                        s_axi_bvalid <= 1'b0;
                        state        <= clint_pkg::IDLE;
                    end
                end
                default:
                begin
                    state <= clint_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (aw_hs)
        begin
            id_q <= s_axi_awid;
        end
        else if (ar_hs)
        begin
            id_q <= s_axi_arid;
        end
        if ((state == clint_pkg::READ_RESP) && !s_axi_rvalid)
        begin
            rdata_q <= (reg_sel == clint_pkg::SEL_NONE) ? 32'h0 : reg_rdata;
        end
        if (w_hs)
        begin
            reg_wdata <= s_axi_wdata;
            reg_wstrb <= s_axi_wstrb;
        end
    end

endmodule

// File: source/clint_mtime.sv
module clint_mtime #(
    parameter int TICK_DIV = 4
) (
    input  logic                clock,
    input  logic                S_AXI_ARESETN,
    input  logic                reg_wr,
    input  clint_pkg::reg_sel_e reg_sel,
    input  logic [31:0]         reg_wdata,
    input  logic [3:0]          reg_wstrb,
    output logic [63:0]         mtime
);

    localparam int PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PW-1:0] presc;
    logic          tick;
    logic          wr_lo;
    logic          wr_hi;

    assign tick  = (presc == PW'(TICK_DIV - 1));
    assign wr_lo = reg_wr && (reg_sel == clint_pkg::SEL_TIME_LO);
    assign wr_hi = reg_wr && (reg_sel == clint_pkg::SEL_TIME_HI);

    always_ff @(posedge clock or negedge S_AXI_ARESETN)
    begin
        if (!S_AXI_ARESETN)
        begin
            presc <= '0;
            mtime <= 64'h0;
        end
        else if (wr_lo)
        begin
            // a load restarts the prescaler and skips this tick
            presc        <= '0;
            mtime[31:0]  <= clint_pkg::strobe_merge(mtime[31:0], reg_wdata, reg_wstrb);
        end
        else if (wr_hi)
        begin
            presc        <= '0;
            mtime[63:32] <= clint_pkg::strobe_merge(mtime[63:32], reg_wdata, reg_wstrb);
        end
        else if (tick)
        begin
            presc <= '0;
            mtime <= mtime + 64'd1;
        end
        else
        begin
            presc <= presc + 1'b1;
        end
    end

endmodule

// File: source/clint_regs.sv
module clint_regs (
    input  logic                clock,
    input  logic                S_AXI_ARESETN,
    input  logic                reg_wr,
    input  clint_pkg::reg_sel_e reg_sel,
    input  logic [31:0]         reg_wdata,
    input  logic [3:0]          reg_wstrb,
    input  logic [63:0]         mtime,
    output logic [31:0]         reg_rdata,
    output logic                timer_irq,
    output logic                soft_irq
);

    logic        msip;
    logic [63:0] mtimecmp;
    logic [31:0] cmp_lo_next;
    logic [31:0] cmp_hi_next;

    assign cmp_lo_next = clint_pkg::strobe_merge(mtimecmp[31:0], reg_wdata, reg_wstrb);
    assign cmp_hi_next = clint_pkg::strobe_merge(mtimecmp[63:32], reg_wdata, reg_wstrb);

    always_ff @(posedge clock or negedge S_AXI_ARESETN)
    begin
        if (!S_AXI_ARESETN)
        begin
            msip     <= 1'b0;
            // all ones keeps the timer interrupt quiet until software sets it
            mtimecmp <= '1;
        end
        else if (reg_wr)
        begin
            case (reg_sel)
                clint_pkg::SEL_MSIP:
                begin
                    // only byte 0 carries the msip bit
                    if (reg_wstrb[0])
                    begin
                        msip <= reg_wdata[0];
                    end
                end
                clint_pkg::SEL_CMP_LO: mtimecmp[31:0]  <= cmp_lo_next;
                clint_pkg::SEL_CMP_HI: mtimecmp[63:32] <= cmp_hi_next;
                default:
                begin
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge S_AXI_ARESETN)
    begin
        if (!S_AXI_ARESETN)
        begin
            timer_irq <= 1'b0;
            soft_irq  <= 1'b0;
        end
        else
        begin
            timer_irq <= (mtime >= mtimecmp);
            soft_irq  <= msip;
        end
    end

    // read word for the selected register
    always_comb
    begin
        case (reg_sel)
            clint_pkg::SEL_MSIP:    reg_rdata = {31'h0, msip};
            clint_pkg::SEL_CMP_LO:  reg_rdata = mtimecmp[31:0];
            clint_pkg::SEL_CMP_HI:  reg_rdata = mtimecmp[63:32];
            clint_pkg::SEL_TIME_LO: reg_rdata = mtime[31:0];
            clint_pkg::SEL_TIME_HI: reg_rdata = mtime[63:32];
            clint_pkg::SEL_NONE:    reg_rdata = 32'h0;
            default:                reg_rdata = 32'h0;
        endcase
    end

endmodule

// File: source/clint.sv
module clint #(
    parameter int TICK_DIV = 4
) (
    input  logic        clock,
    input  logic        S_AXI_ARESETN,
    // read address channel
    input  logic [31:0] s_axi_araddr,
    input  logic        s_axi_arvalid,
    output logic        s_axi_arready,
    input  logic [3:0]  s_axi_arid,
    input  logic [7:0]  s_axi_arlen,
    input  logic [2:0]  s_axi_arsize,
    input  logic [1:0]  s_axi_arburst,
    // read data channel
    output logic [31:0] s_axi_rdata,
    output logic [1:0]  s_axi_rresp,
    output logic        s_axi_rvalid,
    input  logic        s_axi_rready,
    output logic        s_axi_rlast,
    output logic [3:0]  s_axi_rid,
    // write address channel
    input  logic [31:0] s_axi_awaddr,
    input  logic        s_axi_awvalid,
    output logic        s_axi_awready,
    input  logic [3:0]  s_axi_awid,
    input  logic [7:0]  s_axi_awlen,
    input  logic [2:0]  s_axi_awsize,
    input  logic [1:0]  s_axi_awburst,
    // write data channel
    input  logic [31:0] s_axi_wdata,
    input  logic [3:0]  s_axi_wstrb,
    input  logic        s_axi_wvalid,
    input  logic        s_axi_wlast,
    output logic        s_axi_wready,
    // write response channel
    output logic [1:0]  s_axi_bresp,
    output logic        s_axi_bvalid,
    input  logic        s_axi_bready,
    output logic [3:0]  s_axi_bid,
    // to the hart
    output logic        timer_irq,
    output logic        soft_irq
);

    logic                reg_wr;
    clint_pkg::reg_sel_e reg_sel;
    logic [31:0]         reg_wdata;
    logic [3:0]          reg_wstrb;
    logic [31:0]         reg_rdata;
    logic [63:0]         mtime;

    // every access is a single beat
    assign s_axi_rlast = 1'b1;

    clint_axi_fsm fsm_i (
        .clock         (clock),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arid    (s_axi_arid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rready  (s_axi_rready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rid     (s_axi_rid),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awid    (s_axi_awid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bready  (s_axi_bready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bid     (s_axi_bid),
        .reg_rdata     (reg_rdata),
        .reg_wr        (reg_wr),
        .reg_sel       (reg_sel),
        .reg_wdata     (reg_wdata),
        .reg_wstrb     (reg_wstrb)
    );

    clint_mtime #(
        .TICK_DIV (TICK_DIV)
    ) mtime_i (
        .clock         (clock),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .reg_wr        (reg_wr),
        .reg_sel       (reg_sel),
        .reg_wdata     (reg_wdata),
        .reg_wstrb     (reg_wstrb),
        .mtime         (mtime)
    );

    clint_regs regs_i (
        .clock         (clock),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .reg_wr        (reg_wr),
        .reg_sel       (reg_sel),
        .reg_wdata     (reg_wdata),
        .reg_wstrb     (reg_wstrb),
        .mtime         (mtime),
        .reg_rdata     (reg_rdata),
        .timer_irq     (timer_irq),
        .soft_irq      (soft_irq)
    );

endmodule

// File: test/clint_tb.sv
module clint_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLE_LIMIT = 3000;

    // CLINT offsets, address bits 15:0
    localparam logic [15:0] OFF_MSIP     = 16'h0000;
    localparam logic [15:0] OFF_CMP_LO   = 16'h4000;
    localparam logic [15:0] OFF_CMP_HI   = 16'h4004;
    localparam logic [15:0] OFF_TIME_LO  = 16'hBFF8;
    localparam logic [15:0] OFF_TIME_HI  = 16'hBFFC;
    localparam logic [15:0] OFF_UNMAPPED = 16'h1000;
    localparam logic [1:0]  OKAY         = 2'b00;
    localparam logic [1:0]  SLVERR       = 2'b10;

    logic        clock;
    logic        S_AXI_ARESETN;
    logic [31:0] s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [3:0]  s_axi_arid;
    logic [7:0]  s_axi_arlen;
    logic [2:0]  s_axi_arsize;
    logic [1:0]  s_axi_arburst;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic        s_axi_rlast;
    logic [3:0]  s_axi_rid;
    logic [31:0] s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [3:0]  s_axi_awid;
    logic [7:0]  s_axi_awlen;
    logic [2:0]  s_axi_awsize;
    logic [1:0]  s_axi_awburst;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wlast;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [3:0]  s_axi_bid;
    logic        timer_irq;
    logic        soft_irq;

    int          cycle_count = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    string       test_name = "";
    logic [31:0] seed = 32'h8c83de15;
    // expected register contents
    logic [63:0] cmp_model;
    logic        msip_model;

    clint #(
        .TICK_DIV (4)
    ) clint_i (.*);

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("run timed out after %0d cycles in test %s", cycle_count, test_name);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // old word with the strobed bytes taken from the new word
    function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                  input logic [31:0] new_word,
                                                  input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        assert (cond)
        else
        begin
            $display("%s: %s", test_name, msg);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors)
        begin
            $display("test %s: pass", test_name);
            tests_passed++;
        end
        else
        begin
            $display("test %s: fail with %0d errors", test_name, errors - test_errors);
            tests_failed++;
        end
    endtask

    task automatic axi_read(input logic [15:0] offset, input logic [3:0] id, input int rdelay,
                            output logic [31:0] data, output logic [1:0] resp,
                            output logic [3:0] rid, output logic last);
        bit ar_seen;
        ar_seen = 1'b0;
        @(posedge clock);
        s_axi_araddr  <= {16'h0200, offset};
        s_axi_arid    <= id;
        s_axi_arvalid <= 1'b1;
        s_axi_rready  <= 1'b0;
        while (!ar_seen)
        begin
            @(negedge clock);
            ar_seen = s_axi_arready;
            @(posedge clock);
        end
        s_axi_arvalid <= 1'b0;
        do
        begin
            @(negedge clock);
        end
        while (!s_axi_rvalid);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        rid  = s_axi_rid;
        last = s_axi_rlast;
        // response must hold while RREADY stays low
        repeat (rdelay)
        begin
            @(negedge clock);
            check_true(s_axi_rvalid && s_axi_rdata == data && s_axi_rid == rid,
                       "RVALID or R payload changed while RREADY was low");
        end
        @(posedge clock);
        s_axi_rready <= 1'b1;
        @(posedge clock);
        s_axi_rready <= 1'b0;
    endtask

    task automatic axi_write(input logic [15:0] offset, input logic [31:0] data,
                             input logic [3:0] strb, input logic [3:0] id, input int bdelay,
                             output logic [1:0] resp, output logic [3:0] bid);
        bit aw_done;
        bit w_done;
        bit aw_seen;
        bit w_seen;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge clock);
        s_axi_awaddr  <= {16'h0200, offset};
        s_axi_awid    <= id;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wstrb   <= strb;
        s_axi_wvalid  <= 1'b1;
        s_axi_bready  <= 1'b0;
        while (!(aw_done && w_done))
        begin
            @(negedge clock);
            aw_seen = !aw_done && s_axi_awready;
            w_seen  = !w_done && s_axi_wready;
            @(posedge clock);
            if (aw_seen)
            begin
                s_axi_awvalid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_seen)
            begin
                s_axi_wvalid <= 1'b0;
                w_done = 1'b1;
            end
        end
        do
        begin
            @(negedge clock);
        end
        while (!s_axi_bvalid);
        resp = s_axi_bresp;
        bid  = s_axi_bid;
        repeat (bdelay)
        begin
            @(negedge clock);
            check_true(s_axi_bvalid && s_axi_bresp == resp && s_axi_bid == bid,
                       "BVALID or B payload changed while BREADY was low");
        end
        @(posedge clock);
        s_axi_bready <= 1'b1;
        @(posedge clock);
        s_axi_bready <= 1'b0;
    endtask

    task automatic read_expect(input logic [15:0] offset, input logic [31:0] expected,
                               input string what);
        logic [31:0] data;
        logic [1:0]  resp;
        logic [3:0]  rid;
        logic        last;
        axi_read(offset, 4'h0, 0, data, resp, rid, last);
        check_value(what, expected, data);
        check_value({what, " RRESP"}, 32'(OKAY), 32'(resp));
        check_value({what, " RLAST"}, 32'h1, 32'(last));
    endtask

    task automatic write_ok(input logic [15:0] offset, input logic [31:0] data,
                            input logic [3:0] strb);
        logic [1:0] resp;
        logic [3:0] bid;
        axi_write(offset, data, strb, 4'h0, 0, resp, bid);
        check_value("BRESP", 32'(OKAY), 32'(resp));
    endtask

    task automatic reset_state();
        begin_test("reset_state");
        @(negedge clock);
        check_true(!timer_irq && !soft_irq, "interrupt output high after reset");
        check_true(!s_axi_rvalid && !s_axi_bvalid, "response valid high after reset");
        read_expect(OFF_CMP_LO, 32'hFFFF_FFFF, "mtimecmp low");
        read_expect(OFF_CMP_HI, 32'hFFFF_FFFF, "mtimecmp high");
        read_expect(OFF_MSIP, 32'h0, "msip");
        end_test();
    endtask

    task automatic mtime_rate();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] hi;
        logic [1:0]  resp;
        logic [3:0]  rid;
        logic        last;
        int          c0;
        int          c;
        int          delta;
        begin_test("mtime_rate");
        axi_read(OFF_TIME_LO, 4'h0, 0, first, resp, rid, last);
        @(negedge clock);
        c0 = cycle_count;
        repeat (100) @(posedge clock);
        axi_read(OFF_TIME_LO, 4'h0, 0, second, resp, rid, last);
        @(negedge clock);
        c = cycle_count - c0;
        delta = int'(second - first);
        check_true(delta >= c / 4 - 2 && delta <= c / 4 + 2,
                   $sformatf("mtime advanced by %0d in %0d cycles", delta, c));
        hi = next_random();
        write_ok(OFF_TIME_HI, hi, 4'hF);
        read_expect(OFF_TIME_HI, hi, "mtime high");
        end_test();
    endtask

    task automatic strobe_write();
        logic [31:0] data;
        logic [31:0] word;
        logic [31:0] r;
        int          i;
        begin_test("strobe_write");
        for (i = 0; i < 4; i++)
        begin
            data = next_random();
            r = next_random();
            write_ok(OFF_CMP_LO, data, r[31:28]);
            cmp_model[31:0] = apply_strobes(cmp_model[31:0], data, r[31:28]);
            read_expect(OFF_CMP_LO, cmp_model[31:0], "mtimecmp low");
            data = next_random();
            r = next_random();
            write_ok(OFF_CMP_HI, data, r[31:28]);
            cmp_model[63:32] = apply_strobes(cmp_model[63:32], data, r[31:28]);
            read_expect(OFF_CMP_HI, cmp_model[63:32], "mtimecmp high");
            data = next_random();
            // bit 0 toggles msip whenever byte 0 is strobed
            data[0] = ~msip_model;
            r = next_random();
            write_ok(OFF_MSIP, data, r[31:28]);
            // only bit 0 of msip exists
            word = apply_strobes({31'h0, msip_model}, data, r[31:28]);
            msip_model = word[0];
            @(negedge clock);
            check_value("soft_irq", 32'(msip_model), 32'(soft_irq));
            read_expect(OFF_MSIP, {31'h0, msip_model}, "msip");
        end
        end_test();
    endtask

    task automatic timer_interrupt();
        int n;
        begin_test("timer_interrupt");
        write_ok(OFF_CMP_HI, 32'hFFFF_FFFF, 4'hF);
        write_ok(OFF_TIME_HI, 32'h0, 4'hF);
        write_ok(OFF_TIME_LO, 32'h10, 4'hF);
        write_ok(OFF_CMP_LO, 32'h10 + 32'd40, 4'hF);
        write_ok(OFF_CMP_HI, 32'h0, 4'hF);
        cmp_model = {32'h0, 32'h10 + 32'd40};
        @(negedge clock);
        check_value("timer_irq after compare write", 32'h0, 32'(timer_irq));
        n = 0;
        while (!timer_irq && n < 300)
        begin
            @(negedge clock);
            n++;
        end
        check_true(timer_irq, "timer_irq did not rise within 300 cycles");
        write_ok(OFF_CMP_HI, 32'hFFFF_FFFF, 4'hF);
        cmp_model[63:32] = 32'hFFFF_FFFF;
        n = 0;
        while (timer_irq && n < 5)
        begin
            @(negedge clock);
            n++;
        end
        check_true(!timer_irq, "timer_irq did not drop within 5 cycles");
        end_test();
    endtask

    task automatic unmapped_access();
        logic [31:0] data;
        logic [1:0]  resp;
        logic [3:0]  id;
        logic        last;
        begin_test("unmapped_access");
        axi_read(OFF_UNMAPPED, 4'h0, 0, data, resp, id, last);
        check_value("read data", 32'h0, data);
        check_value("RRESP", 32'(SLVERR), 32'(resp));
        axi_write(OFF_UNMAPPED, next_random(), 4'hF, 4'h0, 0, resp, id);
        check_value("BRESP", 32'(SLVERR), 32'(resp));
        read_expect(OFF_CMP_LO, cmp_model[31:0], "mtimecmp low");
        read_expect(OFF_CMP_HI, cmp_model[63:32], "mtimecmp high");
        read_expect(OFF_MSIP, {31'h0, msip_model}, "msip");
        end_test();
    endtask

    task automatic backpressure_ids();
        logic [31:0] data;
        logic [31:0] r;
        logic [1:0]  resp;
        logic [3:0]  rid;
        logic [3:0]  bid;
        logic        last;
        int          i;
        begin_test("backpressure_ids");
        for (i = 0; i < 3; i++)
        begin
            r = next_random();
            axi_read(OFF_CMP_LO, r[31:28], 5, data, resp, rid, last);
            check_value("RID", 32'(r[31:28]), 32'(rid));
            check_value("read data", cmp_model[31:0], data);
            r = next_random();
            data = next_random();
            axi_write(OFF_CMP_HI, data, 4'hF, r[31:28], 5, resp, bid);
            cmp_model[63:32] = data;
            check_value("BID", 32'(r[31:28]), 32'(bid));
            read_expect(OFF_CMP_HI, cmp_model[63:32], "mtimecmp high");
        end
        end_test();
    endtask

    initial
    begin
        S_AXI_ARESETN <= 1'b0;
        s_axi_araddr  <= '0;
        s_axi_arvalid <= 1'b0;
        s_axi_arid    <= '0;
        s_axi_arlen   <= '0;
        s_axi_arsize  <= 3'd2;
        s_axi_arburst <= 2'b01;
        s_axi_rready  <= 1'b0;
        s_axi_awaddr  <= '0;
        s_axi_awvalid <= 1'b0;
        s_axi_awid    <= '0;
        s_axi_awlen   <= '0;
        s_axi_awsize  <= 3'd2;
        s_axi_awburst <= 2'b01;
        s_axi_wdata   <= '0;
        s_axi_wstrb   <= '0;
        s_axi_wvalid  <= 1'b0;
        s_axi_wlast   <= 1'b1;
        s_axi_bready  <= 1'b0;
        cmp_model  = '1;
        msip_model = 1'b0;
        repeat (3) @(posedge clock);
        S_AXI_ARESETN <= 1'b1;
        reset_state();
        mtime_rate();
        strobe_write();
        timer_interrupt();
        unmapped_access();
        backpressure_ids();
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: all.f
source/clint_pkg.sv
source/clint_axi_fsm.sv
source/clint_mtime.sv
source/clint_regs.sv
source/clint.sv
test/clint_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= clint_tb
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG), check the result"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR, TOP, LOG, VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
